//--- source/muldiv_cfg.svh
/*
 * M extension execution block configuration.
 * Data width, word width and iteration count.
 */
`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////
`define MD_XLEN 64        // Operand and result width.
`define MD_WLEN 32        // Word operations.

////////////////////////////////////////////////////////////
// Iteration
////////////////////////////////////////////////////////////
`define MD_ITER `MD_XLEN  // One bit per cycle.
`endif

//--- source/muldiv_pkg.sv
/*
 * M extension shared types.
 * Operation codes, per-request control flags and the data word.
 */
`include "muldiv_cfg.svh"

package muldiv_pkg;

    typedef logic [`MD_XLEN-1:0] md_word_t;

    typedef enum logic [3:0] {
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_MULW,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU,
        OP_DIVW,
        OP_DIVUW,
        OP_REMW,
        OP_REMUW
    } md_op_e;

    // Field order matters for the decode table.
    typedef struct packed {
        logic a_signed;
        logic b_signed;
        logic want_hi;   // High half of product.
        logic want_rem;  // Remainder, not quotient.
        logic word;      // Sign-extend from bit 31.
    } md_ctrl_t;

endpackage

//--- source/md_req_if.sv
/*
 * Conditioned request from the issue controller to one
 * arithmetic unit. Start is a single-cycle strobe.
 */
interface md_req_if;
    import muldiv_pkg::*;

    logic     start;
    md_word_t a;
    md_word_t b;
    md_ctrl_t ctrl;

    modport issue (
        output start,
        output a,
        output b,
        output ctrl
    );

    modport unit (
        input start,
        input a,
        input b,
        input ctrl
    );

endinterface

//--- source/md_issue_ctrl.sv
/*
 * M extension issue controller.
 * Decodes the op, conditions operands, starts one unit,
 * tracks busy, drops starts while busy, registers the result.
 */
`include "muldiv_cfg.svh"

module md_issue_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  muldiv_pkg::md_op_e   op,
    input  muldiv_pkg::md_word_t src1,
    input  muldiv_pkg::md_word_t src2,
    input  logic                 mul_done,
    input  logic                 div_done,
    input  muldiv_pkg::md_word_t mul_result,
    input  muldiv_pkg::md_word_t div_result,
    output logic                 done,
    output muldiv_pkg::md_word_t result,
    output logic                 busy,
    output logic                 dropped,
    md_req_if.issue              mul_req,
    md_req_if.issue              div_req
);
    import muldiv_pkg::*;

    localparam int XL = `MD_XLEN;
    localparam int WL = `MD_WLEN;

    md_ctrl_t ctrl_d;
    md_ctrl_t ctrl_q;
    md_word_t a_d;
    md_word_t b_d;
    md_word_t a_q;
    md_word_t b_q;
    md_word_t res_sel;
    md_word_t res_ext;
    logic     is_div;
    logic     accept;
    logic     unit_done;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////
    // {a_signed, b_signed, want_hi, want_rem, word}
    always_comb begin
        ctrl_d = '0;
        case (op)
            OP_MULH:   ctrl_d = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
            OP_MULHSU: ctrl_d = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
            OP_MULHU:  ctrl_d = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
            OP_MULW:   ctrl_d = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
            OP_DIV:    ctrl_d = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
            OP_REM:    ctrl_d = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
            OP_REMU:   ctrl_d = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
            OP_DIVW:   ctrl_d = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
            OP_DIVUW:  ctrl_d = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
            OP_REMW:   ctrl_d = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
            OP_REMUW:  ctrl_d = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
            default:   ctrl_d = '0;  // MUL and DIVU.
        endcase
    end

    assign is_div = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU,
                               OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};

    // Word ops run at full width on extended operands.
    assign a_d = ctrl_d.word ? {{(XL-WL){ctrl_d.a_signed & src1[WL-1]}}, src1[WL-1:0]} : src1;
    assign b_d = ctrl_d.word ? {{(XL-WL){ctrl_d.b_signed & src2[WL-1]}}, src2[WL-1:0]} : src2;

    assign accept    = start & ~busy;
    assign unit_done = mul_done | div_done;
    assign res_sel   = mul_done ? mul_result : div_result;
    assign res_ext   = ctrl_q.word ? {{(XL-WL){res_sel[WL-1]}}, res_sel[WL-1:0]} : res_sel;

    ////////////////////////////////////////////////////////////
    // Control and result
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            busy          <= 1'b0;
            done          <= 1'b0;
            dropped       <= 1'b0;
            result        <= '0;
            mul_req.start <= 1'b0;
            div_req.start <= 1'b0;
        end else begin
            done          <= unit_done;
            dropped       <= start & busy;
            mul_req.start <= accept & ~is_div;
            div_req.start <= accept & is_div;
            if (accept) begin
                busy <= 1'b1;
            end else if (unit_done) begin
                busy <= 1'b0;
            end
            if (unit_done) begin
                result <= res_ext;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q    <= a_d;
            b_q    <= b_d;
            ctrl_q <= ctrl_d;
        end
    end

    assign mul_req.a    = a_q;
    assign mul_req.b    = b_q;
    assign mul_req.ctrl = ctrl_q;
    assign div_req.a    = a_q;
    assign div_req.b    = b_q;
    assign div_req.ctrl = ctrl_q;

    // Only one unit may be working on a request.
    a_one_unit: assert property (@(posedge clk) disable iff (rst)
        !(mul_done && div_done))
        else $error("both units returned done together");

    a_done_busy: assert property (@(posedge clk) disable iff (rst)
        unit_done |-> busy)
        else $error("unit done while controller idle");

endmodule

//--- source/radix2_divider.sv
/*
 * Radix-2 restoring divider, one quotient bit per cycle.
 * Signed and unsigned, with the RISC-V results for a zero
 * divisor and for signed overflow.
 */
`include "muldiv_cfg.svh"

module radix2_divider (
    input  logic                 clk,
    input  logic                 rst,
    md_req_if.unit               req,
    output logic                 done,
    output muldiv_pkg::md_word_t result
);
    import muldiv_pkg::*;

    localparam int XL = `MD_XLEN;
    localparam int CW = $clog2(`MD_ITER);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_FIN} state_e;

    state_e         state;
    logic [CW-1:0]  cnt;
    logic [2*XL:0]  rem_q;     // {partial remainder, quotient}.
    logic [2*XL:0]  rem_nxt;
    logic [2*XL:0]  shifted;
    logic [XL:0]    diff;
    md_word_t       dvsr;
    md_word_t       dvdnd;
    md_word_t       a_mag;
    md_word_t       b_mag;
    md_word_t       quo;
    md_word_t       rmd;
    logic           a_neg;
    logic           b_neg;
    logic           q_neg;
    logic           r_neg;
    logic           div_zero;
    logic           ovf;
    logic           want_rem;

    assign a_neg = req.ctrl.a_signed & req.a[XL-1];
    assign b_neg = req.ctrl.b_signed & req.b[XL-1];
    assign a_mag = a_neg ? -req.a : req.a;
    assign b_mag = b_neg ? -req.b : req.b;

    ////////////////////////////////////////////////////////////
    // Restoring step
    ////////////////////////////////////////////////////////////
    assign shifted = {rem_q[2*XL-1:0], 1'b0};
    assign diff    = shifted[2*XL:XL] - {1'b0, dvsr};
    assign rem_nxt = (shifted[2*XL:XL] >= {1'b0, dvsr}) ?
                     {diff, shifted[XL-1:1], 1'b1} : shifted;

    // Remainder follows the dividend sign.
    assign quo = q_neg ? -rem_q[XL-1:0] : rem_q[XL-1:0];
    assign rmd = r_neg ? -rem_q[2*XL-1:XL] : rem_q[2*XL-1:XL];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: if (req.start) begin
                    state <= S_RUN;
                    cnt   <= '0;
                end
                S_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CW'(`MD_ITER - 1)) begin
                        state <= S_FIN;
                    end
                end
                default: begin
                    state <= S_IDLE;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req.start) begin
            rem_q    <= {{(XL+1){1'b0}}, a_mag};
            dvsr     <= b_mag;
            dvdnd    <= req.a;
            q_neg    <= a_neg ^ b_neg;
            r_neg    <= a_neg;
            want_rem <= req.ctrl.want_rem;
            div_zero <= (req.b == '0);
            ovf      <= req.ctrl.a_signed && req.a == {1'b1, {(XL-1){1'b0}}} && req.b == '1;
        end else if (state == S_RUN) begin
            rem_q <= rem_nxt;
        end else if (state == S_FIN) begin
            if (div_zero) begin
                result <= want_rem ? dvdnd : '1;
            end else if (ovf) begin
                result <= want_rem ? '0 : dvdnd;  // Quotient wraps.
            end else begin
                result <= want_rem ? rmd : quo;
            end
        end
    end

    // Load, MD_ITER steps, then the final step.
    a_done_latency: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(req.start, `MD_ITER + 2))
        else $error("divider done at the wrong cycle after start");

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        req.start |-> state == S_IDLE)
        else $error("divider started while running");

endmodule

//--- source/shift_add_multiplier.sv
/*
 * Iterative shift-add multiplier, one bit per cycle.
 * Works on magnitudes and returns the high or low half.
 */
`include "muldiv_cfg.svh"

module shift_add_multiplier (
    input  logic                 clk,
    input  logic                 rst,
    md_req_if.unit               req,
    output logic                 done,
    output muldiv_pkg::md_word_t result
);
    import muldiv_pkg::*;

    localparam int XL = `MD_XLEN;
    localparam int CW = $clog2(`MD_ITER);

    logic            running;
    logic [CW-1:0]   cnt;
    logic [2*XL-1:0] prod;       // {accumulator, multiplier}.
    logic [2*XL-1:0] prod_nxt;
    logic [2*XL-1:0] prod_fin;
    logic [XL:0]     sum;
    md_word_t        mcand;
    md_word_t        a_mag;
    md_word_t        b_mag;
    logic            a_neg;
    logic            b_neg;
    logic            neg;
    logic            want_hi;
    logic            last;

    assign a_neg = req.ctrl.a_signed & req.a[XL-1];
    assign b_neg = req.ctrl.b_signed & req.b[XL-1];
    assign a_mag = a_neg ? -req.a : req.a;
    assign b_mag = b_neg ? -req.b : req.b;

    assign sum      = {1'b0, prod[2*XL-1:XL]} + (prod[0] ? {1'b0, mcand} : '0);
    assign prod_nxt = {sum, prod[XL-1:1]};
    assign prod_fin = neg ? -prod_nxt : prod_nxt;
    assign last     = running && cnt == CW'(`MD_ITER - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            cnt     <= '0;
            done    <= 1'b0;
        end else begin
            done <= last;
            if (req.start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    running <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.start) begin
            mcand   <= a_mag;
            prod    <= {{XL{1'b0}}, b_mag};
            neg     <= a_neg ^ b_neg;
            want_hi <= req.ctrl.want_hi;
        end else if (running) begin
            prod <= prod_nxt;
            if (last) begin
                result <= want_hi ? prod_fin[2*XL-1:XL] : prod_fin[XL-1:0];
            end
        end
    end

    // Load, then MD_ITER shift-add steps.
    a_done_latency: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(req.start, `MD_ITER + 1))
        else $error("multiplier done at the wrong cycle after start");

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        req.start |-> !running)
        else $error("multiplier started while running");

endmodule

//--- source/muldiv_unit.sv
/*
 * RV64 M extension execution block.
 * Issue controller with a shift-add multiplier and a
 * restoring divider behind it.
 */
module muldiv_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  muldiv_pkg::md_op_e   op,
    input  muldiv_pkg::md_word_t src1,
    input  muldiv_pkg::md_word_t src2,
    output logic                 done,
    output muldiv_pkg::md_word_t result,
    output logic                 busy,
    output logic                 dropped
);
    import muldiv_pkg::*;

    logic     mul_done;
    logic     div_done;
    md_word_t mul_result;
    md_word_t div_result;

    md_req_if mul_req ();
    md_req_if div_req ();

    md_issue_ctrl i_issue (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .src1       (src1),
        .src2       (src2),
        .mul_done   (mul_done),
        .div_done   (div_done),
        .mul_result (mul_result),
        .div_result (div_result),
        .done       (done),
        .result     (result),
        .busy       (busy),
        .dropped    (dropped),
        .mul_req    (mul_req.issue),
        .div_req    (div_req.issue)
    );

    shift_add_multiplier i_mul (
        .clk    (clk),
        .rst    (rst),
        .req    (mul_req.unit),
        .done   (mul_done),
        .result (mul_result)
    );

    radix2_divider i_div (
        .clk    (clk),
        .rst    (rst),
        .req    (div_req.unit),
        .done   (div_done),
        .result (div_result)
    );

endmodule

//--- verification/muldiv_tb.sv
/*
 * Testbench for the RV64 M extension execution block.
 * Directed tests against a reference model of the RISC-V rules.
 */
module muldiv_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import muldiv_pkg::*;

    localparam int TIMEOUT = 200;
    localparam md_word_t MIN = 64'h8000_0000_0000_0000;

    logic     clk;
    logic     rst;
    logic     start;
    md_op_e   op;
    md_word_t src1;
    md_word_t src2;
    logic     done;
    md_word_t result;
    logic     busy;
    logic     dropped;

    integer seed;
    int     checks;
    int     errors;
    int     tests;

    md_word_t corners [7] = '{64'd0, 64'd1, '1, MIN, 64'h7FFF_FFFF_FFFF_FFFF,
                              64'hFFFF_FFFF_FFFF_FFF9, 64'h0123_4567_8000_0000};
    md_op_e   mul_ops [5] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW};
    md_op_e   div_ops [8] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU,
                              OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};

    muldiv_unit i_dut (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .op      (op),
        .src1    (src1),
        .src2    (src2),
        .done    (done),
        .result  (result),
        .busy    (busy),
        .dropped (dropped)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic md_word_t ref_result(md_op_e o, md_word_t a, md_word_t b);
        logic [127:0]       ea;
        logic [127:0]       eb;
        logic [127:0]       prod;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] sa_w;
        logic signed [31:0] sb_w;
        logic [31:0]        ua_w;
        logic [31:0]        ub_w;
        logic [31:0]        res_w;
        md_word_t           res;
        sa   = a;
        sb   = b;
        ua_w = a[31:0];
        ub_w = b[31:0];
        sa_w = a[31:0];
        sb_w = b[31:0];
        ea   = {{64{a[63] & (o == OP_MULH || o == OP_MULHSU)}}, a};
        eb   = {{64{b[63] & (o == OP_MULH)}}, b};
        prod = ea * eb;  // Low 128 bits are exact.
        res   = '0;
        res_w = '0;
        case (o)
            OP_MUL:                       res = prod[63:0];
            OP_MULH, OP_MULHSU, OP_MULHU: res = prod[127:64];
            OP_MULW:   res_w = ua_w * ub_w;
            OP_DIV, OP_REM: begin
                if (b == '0) begin
                    res = (o == OP_DIV) ? '1 : a;
                end else if (a == MIN && b == '1) begin
                    res = (o == OP_DIV) ? a : '0;
                end else begin
                    res = (o == OP_DIV) ? sa / sb : sa % sb;  // Truncates toward zero.
                end
            end
            OP_DIVU:   res = (b == '0) ? '1 : a / b;
            OP_REMU:   res = (b == '0) ? a : a % b;
            OP_DIVW, OP_REMW: begin
                if (ub_w == '0) begin
                    res_w = (o == OP_DIVW) ? '1 : ua_w;
                end else if (ua_w == 32'h8000_0000 && ub_w == '1) begin
                    res_w = (o == OP_DIVW) ? ua_w : '0;
                end else begin
                    res_w = (o == OP_DIVW) ? sa_w / sb_w : sa_w % sb_w;
                end
            end
            OP_DIVUW:  res_w = (ub_w == '0) ? '1 : ua_w / ub_w;
            OP_REMUW:  res_w = (ub_w == '0) ? ua_w : ua_w % ub_w;
            default:   res = '0;
        endcase
        if (o inside {OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW}) begin
            res = {{32{res_w[31]}}, res_w};
        end
        return res;
    endfunction

    function automatic md_word_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_word(string name, md_word_t got, md_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic report_test(string name, int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %-12s ok", name);
        end else begin
            $display("test %-12s %0d errors", name, errors - err_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////
    // Returns right after the edge that samples start.
    task automatic issue(md_op_e o, md_word_t a, md_word_t b);
        @(posedge clk);
        start <= 1'b1;
        op    <= o;
        src1  <= a;
        src2  <= b;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(output int cycles, output bit ok);
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            ok = done;
        end
        if (!ok) begin
            errors++;
            $display("Timeout: done did not rise within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic run_expect(md_op_e o, md_word_t a, md_word_t b, md_word_t exp,
                              output int cycles);
        bit ok;
        issue(o, a, b);
        wait_done(cycles, ok);
        if (ok) begin
            check_word($sformatf("result %s(%h, %h)", o.name(), a, b), result, exp);
        end else begin
            cycles = -1;
        end
    endtask

    task automatic exec_op(md_op_e o, md_word_t a, md_word_t b, output int cycles);
        run_expect(o, a, b, ref_result(o, a, b), cycles);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset();
        int err0;
        err0 = errors;
        @(negedge clk);
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("dropped", dropped, 1'b0);
        check_word("result", result, '0);
        report_test("reset", err0);
    endtask

    task automatic test_mul_family();
        int       err0;
        int       cycles;
        md_word_t a;
        md_word_t b;
        err0 = errors;
        exec_op(OP_MUL, 64'd3, 64'd5, cycles);
        check_count("mul latency", cycles, 67);
        foreach (mul_ops[k]) begin
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    exec_op(mul_ops[k], corners[i], corners[j], cycles);
                end
            end
            repeat (20) begin
                a = rand_word();
                b = rand_word();
                exec_op(mul_ops[k], a, b, cycles);
            end
        end
        report_test("mul_family", err0);
    endtask

    task automatic test_div_family();
        int       err0;
        int       cycles;
        int       sh;
        md_word_t a;
        md_word_t b;
        err0 = errors;
        exec_op(OP_DIV, 64'd100, 64'hFFFF_FFFF_FFFF_FFF9, cycles);
        check_count("div latency", cycles, 68);
        foreach (div_ops[k]) begin
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    exec_op(div_ops[k], corners[i], corners[j], cycles);
                end
            end
            repeat (20) begin
                sh = $random(seed) & 63;  // Spread of divisor sizes.
                a  = rand_word();
                b  = rand_word() >> sh;
                exec_op(div_ops[k], a, b, cycles);
            end
        end
        report_test("div_family", err0);
    endtask

    task automatic test_special();
        int err0;
        int cycles;
        err0 = errors;
        run_expect(OP_DIV, 64'h1234, '0, '1, cycles);
        run_expect(OP_REM, 64'hFFFF_FFFF_FFFF_FF00, '0, 64'hFFFF_FFFF_FFFF_FF00, cycles);
        run_expect(OP_DIVU, 64'd5, '0, '1, cycles);
        run_expect(OP_REMU, 64'd5, '0, 64'd5, cycles);
        run_expect(OP_DIV, MIN, '1, MIN, cycles);
        run_expect(OP_REM, MIN, '1, '0, cycles);
        // Word divisor is zero although the upper half is not.
        run_expect(OP_DIVW, 64'd100, 64'hFFFF_FFFF_0000_0000, '1, cycles);
        run_expect(OP_REMW, 64'h8000_0001, 64'h1_0000_0000, 64'hFFFF_FFFF_8000_0001, cycles);
        run_expect(OP_DIVUW, 64'd7, '0, '1, cycles);
        run_expect(OP_REMUW, 64'hABCD_0000_7FFF_0000, '0, 64'h7FFF_0000, cycles);
        run_expect(OP_DIVW, 64'h8000_0000, 64'hFFFF_FFFF, 64'hFFFF_FFFF_8000_0000, cycles);
        run_expect(OP_REMW, 64'h8000_0000, 64'hFFFF_FFFF, '0, cycles);
        report_test("special", err0);
    endtask

    task automatic test_busy_drop();
        int       err0;
        int       cycles;
        bit       ok;
        md_word_t exp1;
        md_word_t exp3;
        err0 = errors;
        exp1 = ref_result(OP_MULHU, 64'hDEAD_BEEF_0BAD_F00D, 64'h0FED_CBA9_8765_4321);
        issue(OP_MULHU, 64'hDEAD_BEEF_0BAD_F00D, 64'h0FED_CBA9_8765_4321);
        @(negedge clk);
        check_bit("busy", busy, 1'b1);
        @(posedge clk);
        start <= 1'b1;  // Arrives while busy.
        op    <= OP_DIV;
        src1  <= 64'd99;
        src2  <= 64'd3;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_bit("dropped", dropped, 1'b1);
        check_bit("busy", busy, 1'b1);
        @(negedge clk);
        check_bit("dropped", dropped, 1'b0);
        wait_done(cycles, ok);
        if (ok) begin
            check_word("result after drop", result, exp1);
        end
        // Second op issued right after done.
        issue(OP_REMU, 64'd1000, 64'd7);
        repeat (20) begin
            @(negedge clk);
            check_word("result held", result, exp1);
            check_bit("done", done, 1'b0);
        end
        wait_done(cycles, ok);
        if (ok) begin
            check_word("result REMU", result, 64'd6);
        end
        exp3 = ref_result(OP_MULW, 64'h0000_0001_FFFF_FFFE, 64'd3);
        exec_op(OP_MULW, 64'h0000_0001_FFFF_FFFE, 64'd3, cycles);
        repeat (10) begin
            @(negedge clk);
            check_word("result held", result, exp3);
            check_bit("done", done, 1'b0);
            check_bit("busy", busy, 1'b0);
        end
        report_test("busy_drop", err0);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////
    initial begin
        seed   = 53;
        checks = 0;
        errors = 0;
        tests  = 0;
        rst    = 1'b1;
        start  = 1'b0;
        op     = OP_MUL;
        src1   = '0;
        src2   = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        test_reset();
        test_mul_family();
        test_div_family();
        test_special();
        test_busy_drop();

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- muldiv_unit.f
+incdir+source
source/muldiv_pkg.sv
source/md_req_if.sv
source/md_issue_ctrl.sv
source/radix2_divider.sv
source/shift_add_multiplier.sv
source/muldiv_unit.sv
verification/muldiv_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the muldiv_unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module muldiv_tb -f muldiv_unit.f --Mdir obj_dir -o muldiv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/muldiv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the outcome.
if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
